/* rtl/axi2apb_pkg.sv */
// --------------------
// Shared widths, types and codes for the AXI4 to APB3 bridge
// AXI side is fixed at 64-bit data, APB side at 32-bit data
// Only OKAY and SLVERR responses are produced
// --------------------

package axi2apb_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int APB_DATA_W = 32;
  localparam int AXI_ID_W   = 4;

  typedef logic [AXI_ADDR_W-1:0] addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [7:0]            axi_len_t;   // Beats minus one
  typedef logic [2:0]            axi_size_t;  // log2 bytes per beat
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  localparam axi_size_t SIZE_64    = 3'd3;
  localparam addr_t     WORD_BYTES = 32'd4;  // Low half to high half
  localparam addr_t     BEAT_BYTES = 32'd8;  // Beat to beat in a burst

  // --------------------
  // AXI channel payloads
  typedef struct packed {
    axi_id_t   id;
    addr_t     addr;
    axi_len_t  len;
    axi_size_t size;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // --------------------
  // Sequencer to APB port link
  typedef struct packed {
    logic      write;
    addr_t     addr;
    apb_data_t wdata;
  } apb_cmd_t;

  typedef struct packed {
    apb_data_t rdata;
    logic      err;   // PSLVERR seen on this transfer
  } apb_rsp_t;

endpackage

/* rtl/apb_master_port.sv */
// --------------------
// APB3 master shared by the read and write sequencers
// Read request wins when both wait, grant held for the full req/ack cycle
// At least 2 APB cycles per transfer, ack one cycle after PREADY
// --------------------

`timescale 1ns/100ps

module apb_master_port
(
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  logic                   rd_req_i,
  input  axi2apb_pkg::apb_cmd_t  rd_cmd_i,
  output logic                   rd_ack_o,
  input  logic                   wr_req_i,
  input  axi2apb_pkg::apb_cmd_t  wr_cmd_i,
  output logic                   wr_ack_o,
  output axi2apb_pkg::apb_rsp_t  rsp_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output axi2apb_pkg::addr_t     paddr_o,
  output axi2apb_pkg::apb_data_t pwdata_o,
  input  axi2apb_pkg::apb_data_t prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i
);

  typedef enum logic [1:0] {idle, setup, access, done} port_state_t;

  port_state_t           state_q;
  logic                  grant_rd_q;  // 1 while the read link owns the port
  axi2apb_pkg::apb_cmd_t cmd_q;
  axi2apb_pkg::apb_rsp_t rsp_q;
  logic                  granted_req;

  assign granted_req = grant_rd_q ? rd_req_i : wr_req_i;

  // --------------------
  // APB outputs
  assign psel_o    = (state_q == setup) || (state_q == access);
  assign penable_o = (state_q == access);
  assign pwrite_o  = cmd_q.write;
  assign paddr_o   = cmd_q.addr;
  assign pwdata_o  = cmd_q.wdata;

  assign rd_ack_o = (state_q == done) && grant_rd_q;
  assign wr_ack_o = (state_q == done) && !grant_rd_q;
  assign rsp_o    = rsp_q;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q    <= idle;
      grant_rd_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        idle:
          if (rd_req_i || wr_req_i)
          begin
            grant_rd_q <= rd_req_i;  // Reads first
            state_q    <= setup;
          end
        setup:
          state_q <= access;
        access:
          if (pready_i)
            state_q <= done;
        done:
          if (!granted_req)          // Four-phase release
            state_q <= idle;
        default:
          state_q <= idle;
      endcase
    end
  end

  // Command and result registers
  always_ff @(posedge ACLK)
  begin
    if (state_q == idle)
      cmd_q <= rd_req_i ? rd_cmd_i : wr_cmd_i;
    if (state_q == access && pready_i)
    begin
      rsp_q.rdata <= prdata_i;
      rsp_q.err   <= pslverr_i;
    end
  end

endmodule

/* rtl/axi2apb_rd_seq.sv */
// --------------------
// Read sequencer handling one AR burst at a time
// 64-bit beats read the low word at addr and the high word at addr + 4
// 32-bit reads fill the lane picked by addr[2] and leave the other lane zero
// --------------------

`timescale 1ns/100ps

module axi2apb_rd_seq
(
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  axi2apb_pkg::axi_ax_t  ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi2apb_pkg::axi_r_t   r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic                  apb_req_o,
  output axi2apb_pkg::apb_cmd_t apb_cmd_o,
  input  logic                  apb_ack_i,
  input  axi2apb_pkg::apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {idle, rd_lo, rd_hi, send} rd_state_t;

  rd_state_t              state_q;
  logic                   req_q;
  axi2apb_pkg::axi_id_t   id_q;
  axi2apb_pkg::addr_t     addr_q;    // Current beat address
  axi2apb_pkg::axi_len_t  beats_q;   // Beats left after this one
  axi2apb_pkg::axi_size_t size_q;
  axi2apb_pkg::apb_data_t lo_q;
  axi2apb_pkg::apb_data_t hi_q;
  logic                   err_q;
  logic                   done;      // Current APB read acknowledged

  assign done       = req_q && apb_ack_i;
  assign ar_ready_o = (state_q == idle) && ARESETn;  // Low while in reset
  assign r_valid_o  = (state_q == send);
  assign apb_req_o  = req_q;

  // High half reads the next word
  assign apb_cmd_o.write = 1'b0;
  assign apb_cmd_o.addr  = (state_q == rd_hi) ? addr_q + axi2apb_pkg::WORD_BYTES : addr_q;
  assign apb_cmd_o.wdata = '0;

  assign r_o.id   = id_q;
  assign r_o.data = {hi_q, lo_q};
  assign r_o.resp = err_q ? axi2apb_pkg::RESP_SLVERR : axi2apb_pkg::RESP_OKAY;
  assign r_o.last = (beats_q == '0);

  // --------------------
  // Control
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= idle;
      req_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        idle:
          if (ar_valid_i)
            state_q <= rd_lo;
        rd_lo, rd_hi:
          if (done)
          begin
            req_q <= 1'b0;
            if (state_q == rd_lo && size_q == axi2apb_pkg::SIZE_64)
              state_q <= rd_hi;
            else
              state_q <= send;
          end
          else if (!req_q && !apb_ack_i)  // Previous ack gone
            req_q <= 1'b1;
        send:
          if (r_ready_i)
            state_q <= (beats_q == '0) ? idle : rd_lo;
        default:
          state_q <= idle;
      endcase
    end
  end

  // --------------------
  // Beat data and bookkeeping
  always_ff @(posedge ACLK)
  begin
    if (state_q == idle && ar_valid_i)
    begin
      id_q    <= ar_i.id;
      addr_q  <= ar_i.addr;
      beats_q <= ar_i.len;
      size_q  <= ar_i.size;
      lo_q    <= '0;
      hi_q    <= '0;
      err_q   <= 1'b0;
    end
    else if (done)
    begin
      err_q <= err_q | apb_rsp_i.err;
      if (state_q == rd_hi || (size_q != axi2apb_pkg::SIZE_64 && addr_q[2]))
        hi_q <= apb_rsp_i.rdata;
      else
        lo_q <= apb_rsp_i.rdata;
    end
    else if (state_q == send && r_ready_i && beats_q != '0)
    begin
      addr_q  <= addr_q + axi2apb_pkg::BEAT_BYTES;
      beats_q <= beats_q - axi2apb_pkg::axi_len_t'(1);
      lo_q    <= '0;
      hi_q    <= '0;
      err_q   <= 1'b0;  // Error is per beat
    end
  end

endmodule

/* rtl/axi2apb_wr_seq.sv */
// --------------------
// Write sequencer handling one AW burst at a time
// W beat is held until its last APB write is acked and then popped
// 32-bit writes send the lane picked by addr[2]
// One B per burst that reports SLVERR if any transfer failed
// --------------------

`timescale 1ns/100ps

module axi2apb_wr_seq
(
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  axi2apb_pkg::axi_ax_t  aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi2apb_pkg::axi_w_t   w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi2apb_pkg::axi_b_t   b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic                  apb_req_o,
  output axi2apb_pkg::apb_cmd_t apb_cmd_o,
  input  logic                  apb_ack_i,
  input  axi2apb_pkg::apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {idle, wr_lo, wr_hi, resp} wr_state_t;

  wr_state_t              state_q;
  logic                   req_q;
  axi2apb_pkg::axi_id_t   id_q;
  axi2apb_pkg::addr_t     addr_q;
  axi2apb_pkg::axi_len_t  beats_q;
  axi2apb_pkg::axi_size_t size_q;
  logic                   err_q;     // Sticky over the whole burst
  logic                   done;
  logic                   beat_end;  // Last APB write of the beat acked
  logic                   hi_lane;

  assign done     = req_q && apb_ack_i;
  assign beat_end = done && (state_q == wr_hi || size_q != axi2apb_pkg::SIZE_64);
  assign hi_lane  = (state_q == wr_hi) || (size_q != axi2apb_pkg::SIZE_64 && addr_q[2]);

  assign aw_ready_o = (state_q == idle) && ARESETn;  // Low while in reset
  assign w_ready_o  = beat_end;              // One-cycle pop
  assign b_valid_o  = (state_q == resp);
  assign apb_req_o  = req_q;

  always_comb
  begin
    apb_cmd_o.write = 1'b1;
    apb_cmd_o.addr  = addr_q;
    apb_cmd_o.wdata = w_i.data[31:0];
    if (hi_lane)
      apb_cmd_o.wdata = w_i.data[63:32];
    if (state_q == wr_hi)
      apb_cmd_o.addr = addr_q + axi2apb_pkg::WORD_BYTES;
  end

  assign b_o.id   = id_q;
  assign b_o.resp = err_q ? axi2apb_pkg::RESP_SLVERR : axi2apb_pkg::RESP_OKAY;

  // --------------------
  // Control
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= idle;
      req_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        idle:
          if (aw_valid_i)
            state_q <= wr_lo;
        wr_lo, wr_hi:
          if (done)
          begin
            req_q <= 1'b0;
            if (!beat_end)
              state_q <= wr_hi;
            else if (beats_q == '0)
              state_q <= resp;
            else
              state_q <= wr_lo;
          end
          else if (!req_q && !apb_ack_i && w_valid_i)  // Need data and a free link
            req_q <= 1'b1;
        resp:
          if (b_ready_i)
            state_q <= idle;
        default:
          state_q <= idle;
      endcase
    end
  end

  // --------------------
  // Burst bookkeeping
  always_ff @(posedge ACLK)
  begin
    if (state_q == idle && aw_valid_i)
    begin
      id_q    <= aw_i.id;
      addr_q  <= aw_i.addr;
      beats_q <= aw_i.len;
      size_q  <= aw_i.size;
      err_q   <= 1'b0;
    end
    else if (done)
    begin
      err_q <= err_q | apb_rsp_i.err;
      if (beat_end && beats_q != '0)
      begin
        addr_q  <= addr_q + axi2apb_pkg::BEAT_BYTES;
        beats_q <= beats_q - axi2apb_pkg::axi_len_t'(1);
      end
    end
  end

endmodule

/* rtl/axi2apb_bridge.sv */
// --------------------
// AXI4 slave (64-bit) to APB3 master (32-bit) bridge
// INCR bursts only, no WSTRB, no channel buffering
// One read and one write may overlap, reads win the APB port
// --------------------

`timescale 1ns/100ps

module axi2apb_bridge
(
  input  logic                   ACLK,
  input  logic                   ARESETn,
  // AXI read address
  input  axi2apb_pkg::axi_ax_t   ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  // AXI write address
  input  axi2apb_pkg::axi_ax_t   aw_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  // AXI write data
  input  axi2apb_pkg::axi_w_t    w_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  // AXI read data
  output axi2apb_pkg::axi_r_t    r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  // AXI write response
  output axi2apb_pkg::axi_b_t    b_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  // APB3 master
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output axi2apb_pkg::addr_t     paddr_o,
  output axi2apb_pkg::apb_data_t pwdata_o,
  input  axi2apb_pkg::apb_data_t prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i
);

  // --------------------
  // Sequencer links to the APB port
  logic                  rd_req;
  logic                  rd_ack;
  axi2apb_pkg::apb_cmd_t rd_cmd;
  logic                  wr_req;
  logic                  wr_ack;
  axi2apb_pkg::apb_cmd_t wr_cmd;
  axi2apb_pkg::apb_rsp_t apb_rsp;  // Shared, qualified by the acks

  axi2apb_rd_seq u_rd_seq
  (
    .ACLK       ( ACLK       ),
    .ARESETn    ( ARESETn    ),
    .ar_i       ( ar_i       ),
    .ar_valid_i ( ar_valid_i ),
    .ar_ready_o ( ar_ready_o ),
    .r_o        ( r_o        ),
    .r_valid_o  ( r_valid_o  ),
    .r_ready_i  ( r_ready_i  ),
    .apb_req_o  ( rd_req     ),
    .apb_cmd_o  ( rd_cmd     ),
    .apb_ack_i  ( rd_ack     ),
    .apb_rsp_i  ( apb_rsp    )
  );

  axi2apb_wr_seq u_wr_seq
  (
    .ACLK       ( ACLK       ),
    .ARESETn    ( ARESETn    ),
    .aw_i       ( aw_i       ),
    .aw_valid_i ( aw_valid_i ),
    .aw_ready_o ( aw_ready_o ),
    .w_i        ( w_i        ),
    .w_valid_i  ( w_valid_i  ),
    .w_ready_o  ( w_ready_o  ),
    .b_o        ( b_o        ),
    .b_valid_o  ( b_valid_o  ),
    .b_ready_i  ( b_ready_i  ),
    .apb_req_o  ( wr_req     ),
    .apb_cmd_o  ( wr_cmd     ),
    .apb_ack_i  ( wr_ack     ),
    .apb_rsp_i  ( apb_rsp    )
  );

  apb_master_port u_apb_port
  (
    .ACLK      ( ACLK      ),
    .ARESETn   ( ARESETn   ),
    .rd_req_i  ( rd_req    ),
    .rd_cmd_i  ( rd_cmd    ),
    .rd_ack_o  ( rd_ack    ),
    .wr_req_i  ( wr_req    ),
    .wr_cmd_i  ( wr_cmd    ),
    .wr_ack_o  ( wr_ack    ),
    .rsp_o     ( apb_rsp   ),
    .psel_o    ( psel_o    ),
    .penable_o ( penable_o ),
    .pwrite_o  ( pwrite_o  ),
    .paddr_o   ( paddr_o   ),
    .pwdata_o  ( pwdata_o  ),
    .prdata_i  ( prdata_i  ),
    .pready_i  ( pready_i  ),
    .pslverr_i ( pslverr_i )
  );

endmodule

/* test/apb_mem_model.sv */
// --------------------
// APB3 slave memory, 256 words of 32 bits, index paddr[9:2]
// Wait states equal paddr[3:2]
// 0x300 to 0x3FF answers PSLVERR, writes dropped, reads zero
// --------------------

`timescale 1ns/100ps

module apb_mem_model
(
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  axi2apb_pkg::addr_t     paddr_i,
  input  axi2apb_pkg::apb_data_t pwdata_i,
  output axi2apb_pkg::apb_data_t prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  axi2apb_pkg::apb_data_t mem [256];
  logic [1:0]             wait_q;     // Access cycles still to stall
  logic                   in_window;

  // Fill depends on the full word address
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = 32'h5a00_0000 | 32'(i * 4);
  end

  assign in_window = (paddr_i[31:8] == 24'h00_0003);
  assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
  assign pslverr_o = pready_o && in_window;
  assign prdata_o  = in_window ? '0 : mem[paddr_i[9:2]];

  always @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      wait_q <= 2'd0;
    else if (psel_i && !penable_i)
      wait_q <= paddr_i[3:2];          // Loaded in setup phase
    else if (psel_i && penable_i && wait_q != 2'd0)
      wait_q <= wait_q - 2'd1;
  end

  always @(posedge ACLK)
  begin
    if (pready_o && pwrite_i && !in_window)
      mem[paddr_i[9:2]] <= pwdata_i;
  end

endmodule

/* test/tb_axi2apb.sv */
// --------------------
// Testbench for the AXI4 to APB3 bridge
// Table rows run one after another and a row of kind both overlaps R and W
// Addresses stay below 0x400 and bursts have up to 4 beats
// --------------------

`timescale 1ns/100ps

module tb_axi2apb;

  localparam logic [1:0] KIND_WR   = 2'd0;
  localparam logic [1:0] KIND_RD   = 2'd1;
  localparam logic [1:0] KIND_BOTH = 2'd2;
  localparam int NUM_ROWS       = 19;
  localparam int TIMEOUT_CYCLES = 200 * NUM_ROWS + 100;

  typedef struct packed {
    logic [1:0]             kind;
    axi2apb_pkg::addr_t     waddr;
    axi2apb_pkg::addr_t     raddr;
    axi2apb_pkg::axi_len_t  len;
    axi2apb_pkg::axi_size_t size;
    axi2apb_pkg::axi_id_t   wid;
    axi2apb_pkg::axi_id_t   rid;
  } row_t;

  logic                   ACLK = 1'b0;
  logic                   ARESETn;
  axi2apb_pkg::axi_ax_t   ar;
  axi2apb_pkg::axi_ax_t   aw;
  axi2apb_pkg::axi_w_t    w;
  axi2apb_pkg::axi_r_t    r;
  axi2apb_pkg::axi_b_t    b;
  logic                   ar_valid, ar_ready, aw_valid, aw_ready;
  logic                   w_valid, w_ready, r_valid, r_ready, b_valid, b_ready;
  logic                   psel, penable, pwrite, pready, pslverr;
  axi2apb_pkg::addr_t     paddr;
  axi2apb_pkg::apb_data_t pwdata;
  axi2apb_pkg::apb_data_t prdata;

  row_t                   rows [NUM_ROWS];
  axi2apb_pkg::apb_data_t shadow [256];       // Expected memory contents
  axi2apb_pkg::axi_data_t wbeat [4];          // Write data of the current row
  int                     r_stall [4];        // RREADY low cycles per beat
  int                     b_stall;
  axi2apb_pkg::axi_resp_t exp_bresp;
  logic [31:0]            lcg_state = 32'h703d_7da9;
  int                     mismatch_count = 0;
  int                     fail_count = 0;
  int                     cycle_count = 0;

  always #4 ACLK = ~ACLK;

  axi2apb_bridge uut
  (
    .ACLK ( ACLK ), .ARESETn ( ARESETn ),
    .ar_i ( ar ), .ar_valid_i ( ar_valid ), .ar_ready_o ( ar_ready ),
    .aw_i ( aw ), .aw_valid_i ( aw_valid ), .aw_ready_o ( aw_ready ),
    .w_i ( w ), .w_valid_i ( w_valid ), .w_ready_o ( w_ready ),
    .r_o ( r ), .r_valid_o ( r_valid ), .r_ready_i ( r_ready ),
    .b_o ( b ), .b_valid_o ( b_valid ), .b_ready_i ( b_ready ),
    .psel_o ( psel ), .penable_o ( penable ), .pwrite_o ( pwrite ),
    .paddr_o ( paddr ), .pwdata_o ( pwdata ),
    .prdata_i ( prdata ), .pready_i ( pready ), .pslverr_i ( pslverr )
  );

  apb_mem_model u_mem
  (
    .ACLK ( ACLK ), .ARESETn ( ARESETn ),
    .psel_i ( psel ), .penable_i ( penable ), .pwrite_i ( pwrite ),
    .paddr_i ( paddr ), .pwdata_i ( pwdata ),
    .prdata_o ( prdata ), .pready_o ( pready ), .pslverr_o ( pslverr )
  );

  // --------------------
  // Helpers
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic in_window(input axi2apb_pkg::addr_t a);
    return (a >= 32'h300) && (a <= 32'h3ff);
  endfunction

  function automatic axi2apb_pkg::apb_data_t shadow_word(input axi2apb_pkg::addr_t a);
    return in_window(a) ? '0 : shadow[a[9:2]];  // Error window reads zero
  endfunction

  function automatic void store_word(input axi2apb_pkg::addr_t a,
                                     input axi2apb_pkg::apb_data_t d);
    if (!in_window(a))
      shadow[a[9:2]] = d;
  endfunction

  task automatic check_value(input string name, input logic [79:0] exp,
                             input logic [79:0] got);
    if (exp !== got)
    begin
      mismatch_count++;
      $display("mismatch %s exp %0h got %0h", name, exp, got);
    end
  endtask

  // Draws write data and stalls and updates the shadow and expected BRESP
  task automatic prepare_row(input row_t row);
    axi2apb_pkg::addr_t     a;
    axi2apb_pkg::apb_data_t lo;
    axi2apb_pkg::apb_data_t hi;
    logic                   err;
    int                     k;
    err     = 1'b0;
    b_stall = int'(next_rand() % 32'd4);
    for (k = 0; k <= int'(row.len); k++)
    begin
      lo         = next_rand();
      hi         = next_rand();
      wbeat[k]   = {hi, lo};
      r_stall[k] = int'(next_rand() % 32'd4);
      a = row.waddr + axi2apb_pkg::addr_t'(k) * axi2apb_pkg::BEAT_BYTES;
      if (row.kind != KIND_RD && row.size == axi2apb_pkg::SIZE_64)
      begin
        store_word(a, lo);
        store_word(a + axi2apb_pkg::WORD_BYTES, hi);
        err = err | in_window(a) | in_window(a + axi2apb_pkg::WORD_BYTES);
      end
      else if (row.kind != KIND_RD)
      begin
        store_word(a, a[2] ? hi : lo);  // Lane picked by addr[2]
        err = err | in_window(a);
      end
    end
    exp_bresp = err ? axi2apb_pkg::RESP_SLVERR : axi2apb_pkg::RESP_OKAY;
  endtask

  // --------------------
  // AXI write burst and its B response
  task automatic do_write(input row_t row);
    axi2apb_pkg::axi_b_t b_seen;
    int                  k;
    @(posedge ACLK);
    aw       <= '{id: row.wid, addr: row.waddr, len: row.len, size: row.size};
    aw_valid <= 1'b1;
    do @(negedge ACLK); while (!aw_ready);
    @(posedge ACLK);
    aw_valid <= 1'b0;
    for (k = 0; k <= int'(row.len); k++)
    begin
      w       <= '{data: wbeat[k], last: (k == int'(row.len))};
      w_valid <= 1'b1;
      do @(negedge ACLK); while (!w_ready);
      @(posedge ACLK);
    end
    w_valid <= 1'b0;
    do @(negedge ACLK); while (!b_valid);
    b_seen = b;
    check_value("bid", 80'(row.wid), 80'(b.id));
    check_value("bresp", 80'(exp_bresp), 80'(b.resp));
    repeat (b_stall)
    begin
      @(negedge ACLK);
      if (!b_valid)
      begin
        fail_count++;
        $display("B valid dropped while BREADY was low");
      end
      check_value("b held", 80'(b_seen), 80'(b));
    end
    @(posedge ACLK);
    b_ready <= 1'b1;
    @(posedge ACLK);
    b_ready <= 1'b0;
  endtask

  // --------------------
  // AXI read burst with one check set per beat
  task automatic do_read(input row_t row);
    axi2apb_pkg::addr_t     a;
    axi2apb_pkg::axi_data_t exp_data;
    axi2apb_pkg::axi_r_t    r_seen;
    logic                   err;
    int                     k;
    @(posedge ACLK);
    ar       <= '{id: row.rid, addr: row.raddr, len: row.len, size: row.size};
    ar_valid <= 1'b1;
    do @(negedge ACLK); while (!ar_ready);
    @(posedge ACLK);
    ar_valid <= 1'b0;
    for (k = 0; k <= int'(row.len); k++)
    begin
      a = row.raddr + axi2apb_pkg::addr_t'(k) * axi2apb_pkg::BEAT_BYTES;
      if (row.size == axi2apb_pkg::SIZE_64)
      begin
        exp_data = {shadow_word(a + axi2apb_pkg::WORD_BYTES), shadow_word(a)};
        err      = in_window(a) || in_window(a + axi2apb_pkg::WORD_BYTES);
      end
      else
      begin
        exp_data = a[2] ? {shadow_word(a), 32'h0} : {32'h0, shadow_word(a)};
        err      = in_window(a);
      end
      do @(negedge ACLK); while (!r_valid);
      r_seen = r;
      check_value("rid", 80'(row.rid), 80'(r.id));
      check_value("rdata", 80'(exp_data), 80'(r.data));
      check_value("rresp",
                  80'(err ? axi2apb_pkg::RESP_SLVERR : axi2apb_pkg::RESP_OKAY), 80'(r.resp));
      check_value("rlast", 80'(k == int'(row.len)), 80'(r.last));
      repeat (r_stall[k])
      begin
        @(negedge ACLK);
        if (!r_valid)
        begin
          fail_count++;
          $display("R valid dropped while RREADY was low");
        end
        check_value("r held", 80'(r_seen), 80'(r));
      end
      @(posedge ACLK);
      r_ready <= 1'b1;
      @(posedge ACLK);
      r_ready <= 1'b0;
    end
  endtask

  // --------------------
  // Run limit
  always @(posedge ACLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial
  begin
    int i;
    ARESETn  = 1'b0;
    ar       = '0;
    aw       = '0;
    w        = '0;
    ar_valid = 1'b0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    for (i = 0; i < 256; i++)
      shadow[i] = 32'h5a00_0000 | 32'(i * 4);  // Fill of the memory model
    // kind, waddr, raddr, len, size, wid, rid
    rows = '{
      '{KIND_WR,   32'h040, 32'h000, 8'd0, 3'd3, 4'd1,  4'd0},
      '{KIND_RD,   32'h000, 32'h040, 8'd0, 3'd3, 4'd0,  4'd2},
      '{KIND_WR,   32'h084, 32'h000, 8'd0, 3'd2, 4'd3,  4'd0},  // High lane
      '{KIND_RD,   32'h000, 32'h084, 8'd0, 3'd2, 4'd0,  4'd4},
      '{KIND_WR,   32'h090, 32'h000, 8'd0, 3'd2, 4'd5,  4'd0},  // Low lane
      '{KIND_RD,   32'h000, 32'h090, 8'd0, 3'd2, 4'd0,  4'd6},
      '{KIND_WR,   32'h100, 32'h000, 8'd3, 3'd3, 4'd7,  4'd0},
      '{KIND_RD,   32'h000, 32'h100, 8'd3, 3'd3, 4'd0,  4'd8},
      '{KIND_WR,   32'h140, 32'h000, 8'd1, 3'd3, 4'd9,  4'd0},
      '{KIND_RD,   32'h000, 32'h140, 8'd1, 3'd3, 4'd0,  4'd10},
      '{KIND_WR,   32'h180, 32'h000, 8'd2, 3'd3, 4'd11, 4'd0},
      '{KIND_RD,   32'h000, 32'h180, 8'd2, 3'd3, 4'd0,  4'd12},
      '{KIND_WR,   32'h2f0, 32'h000, 8'd3, 3'd3, 4'd13, 4'd0},  // Runs into error window
      '{KIND_RD,   32'h000, 32'h2f0, 8'd3, 3'd3, 4'd0,  4'd14},
      '{KIND_BOTH, 32'h200, 32'h100, 8'd3, 3'd3, 4'd15, 4'd1},
      '{KIND_RD,   32'h000, 32'h200, 8'd3, 3'd3, 4'd0,  4'd2},
      '{KIND_BOTH, 32'h3f8, 32'h040, 8'd0, 3'd3, 4'd3,  4'd4},
      '{KIND_BOTH, 32'h0a0, 32'h180, 8'd2, 3'd3, 4'd5,  4'd6},
      '{KIND_RD,   32'h000, 32'h0a0, 8'd2, 3'd3, 4'd0,  4'd7}
    };
    repeat (7) @(posedge ACLK);
    // Handshake and APB outputs stay low in reset
    @(negedge ACLK);
    check_value("ar_ready", 80'h0, 80'(ar_ready));
    check_value("aw_ready", 80'h0, 80'(aw_ready));
    check_value("w_ready", 80'h0, 80'(w_ready));
    check_value("r_valid", 80'h0, 80'(r_valid));
    check_value("b_valid", 80'h0, 80'(b_valid));
    check_value("psel", 80'h0, 80'(psel));
    check_value("penable", 80'h0, 80'(penable));
    @(posedge ACLK);
    ARESETn <= 1'b1;
    for (i = 0; i < NUM_ROWS; i++)
    begin
      prepare_row(rows[i]);
      case (rows[i].kind)
        KIND_WR: do_write(rows[i]);
        KIND_RD: do_read(rows[i]);
        default:
          fork
            do_write(rows[i]);
            do_read(rows[i]);
          join
      endcase
    end
    repeat (4) @(posedge ACLK);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* axi2apb_bridge.f */
rtl/axi2apb_pkg.sv
rtl/apb_master_port.sv
rtl/axi2apb_rd_seq.sv
rtl/axi2apb_wr_seq.sv
rtl/axi2apb_bridge.sv
test/apb_mem_model.sv
test/tb_axi2apb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI4 to APB bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_axi2apb \
  -f axi2apb_bridge.f \
  --Mdir obj_dir -o sim_axi2apb

./obj_dir/sim_axi2apb > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log
then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
